// File: memBusPkg.sv
// Word, address and burst length types
// External burst command and data beat structs
`default_nettype none

package memBusPkg;

	localparam int DataWidth = 16;	// Data word width
	localparam int AddrWidth = 22;	// Word address width
	localparam int LenWidth  = 8;	// Burst length width

	typedef logic [DataWidth-1:0] word_t;
	typedef logic [AddrWidth-1:0] addr_t;
	typedef logic [LenWidth-1:0]  len_t;

	// ========================================
	// External burst bus
	// ========================================

	// One burst command, high for a single cycle
	typedef struct packed {
		logic  valid;
		logic  write;	// 1 write burst, 0 read burst
		addr_t addr;	// First word of burst
		len_t  len;	// Number of data beats
	} memCmd_t;

	// Data beat, same shape for write and read direction
	typedef struct packed {
		logic  valid;
		word_t data;
	} beat_t;

endpackage

`default_nettype wire

// File: portPkg.sv
// Port counts, FIFO depth and fill level type
// Stream configuration, grant struct and address ring step
`default_nettype none

package portPkg;

	import memBusPkg::*;

	localparam int NumWritePorts = 2;
	localparam int NumReadPorts  = 2;
	localparam int FifoDepth     = 64;	// Twice the largest burst of 32
	localparam int MaxPorts      = (NumWritePorts > NumReadPorts) ? NumWritePorts : NumReadPorts;
	localparam int PortIdxWidth  = (MaxPorts > 1) ? $clog2(MaxPorts) : 1;

	typedef logic [$clog2(FifoDepth + 1)-1:0] used_t;	// 0 .. FifoDepth

	// Per-stream ring setup
	typedef struct packed {
		addr_t startAddr;	// First burst address
		addr_t wrapAddr;	// First address past the ring
		len_t  burstLen;	// Zero disables the stream
	} streamCfg_t;

	typedef struct packed {
		logic                    valid;
		logic                    read;	// Read port when set, else write port
		logic [PortIdxWidth-1:0] port;
	} grant_t;

	// Ring step after a burst, back to start if next burst would pass wrap
	function automatic addr_t nextRingAddr(addr_t addr, streamCfg_t cfg);
		addr_t stepAddr;
		stepAddr = addr + addr_t'(cfg.burstLen);
		if (stepAddr + addr_t'(cfg.burstLen) > cfg.wrapAddr)
			return cfg.startAddr;
		return stepAddr;
	endfunction

endpackage

`default_nettype wire

// File: portFifo.sv
// Single-clock FIFO with synchronous clear
// Registered read data and fill level
`timescale 1ns/1ps
`default_nettype none

module portFifo
#(
	parameter int Depth = portPkg::FifoDepth	// Power of two
)
(
	input  logic             CLK,
	input  logic             RESET_N,
	input  logic             clear,
	input  logic             push,
	input  memBusPkg::word_t pushData,
	input  logic             pop,
	output memBusPkg::word_t popData,
	output logic             full,
	output logic             empty,
	output portPkg::used_t   used
);

	import memBusPkg::*;

	localparam int PtrWidth = $clog2(Depth);

	word_t               mem [Depth];	// Storage
	logic [PtrWidth-1:0] wrPtr;
	logic [PtrWidth-1:0] rdPtr;
	logic                doPush;
	logic                doPop;

	assign full   = (used == Depth);
	assign empty  = (used == 0);
	assign doPush = push && !full && !clear;	// Drop on full
	assign doPop  = pop && !empty && !clear;	// Empty pop ignored

	// Pointers and occupancy
	always_ff @(posedge CLK or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			used  <= '0;
		end
		else if (clear)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			used  <= '0;
		end
		else
		begin
			if (doPush)
				wrPtr <= wrPtr + 1'b1;	// Wraps at Depth
			if (doPop)
				rdPtr <= rdPtr + 1'b1;
			if (doPush && !doPop)
				used <= used + 1'b1;
			else if (doPop && !doPush)
				used <= used - 1'b1;
		end
	end

	always_ff @(posedge CLK)
	begin
		if (doPush)
			mem[wrPtr] <= pushData;
		if (doPop)
			popData <= mem[rdPtr];	// Head word the cycle after pop
	end

endmodule

`default_nettype wire

// File: writeChannel.sv
// Write stream channel
// FIFO, address ring and full-burst request
`timescale 1ns/1ps
`default_nettype none

module writeChannel
(
	input  logic                CLK,
	input  logic                RESET_N,
	input  portPkg::streamCfg_t cfg,
	input  logic                clear,
	input  memBusPkg::beat_t    userBeat,
	output logic                ready,
	input  logic                beatSel,	// Pop one word toward memory
	output memBusPkg::word_t    memData,
	input  logic                burstDone,
	output logic                burstReq,
	output memBusPkg::addr_t    addr
);

	import memBusPkg::*;
	import portPkg::*;

	logic  fifoFull;
	used_t fifoUsed;

	portFifo i_fifo
	(
		.CLK      (CLK),
		.RESET_N  (RESET_N),
		.clear    (clear),
		.push     (userBeat.valid),	// Taken when valid and ready
		.pushData (userBeat.data),
		.pop      (beatSel),
		.popData  (memData),
		.full     (fifoFull),
		.empty    (),
		.used     (fifoUsed)
	);

	assign ready = !fifoFull;

	// Whole burst waiting, stream enabled
	assign burstReq = (cfg.burstLen != '0) && (len_t'(fifoUsed) >= cfg.burstLen);

	// ========================================
	// Address ring
	// ========================================
	always_ff @(posedge CLK or negedge RESET_N)
	begin
		if (!RESET_N)
			addr <= '0;
		else if (clear)
			addr <= cfg.startAddr;	// Rewind
		else if (burstDone)
			addr <= nextRingAddr(addr, cfg);
	end

endmodule

`default_nettype wire

// File: readChannel.sv
// Read stream channel
// FIFO, address ring and refill request
`timescale 1ns/1ps
`default_nettype none

module readChannel
(
	input  logic                CLK,
	input  logic                RESET_N,
	input  portPkg::streamCfg_t cfg,
	input  logic                clear,
	input  logic                beatSel,	// This channel owns the read burst
	input  memBusPkg::beat_t    memBeat,
	input  logic                pop,
	output memBusPkg::beat_t    userBeat,
	input  logic                burstDone,
	output logic                burstReq,
	output memBusPkg::addr_t    addr
);

	import memBusPkg::*;
	import portPkg::*;

	logic  fifoEmpty;
	used_t fifoUsed;
	word_t fifoData;
	logic  rdValid;	// Pop accepted last cycle

	portFifo i_fifo
	(
		.CLK      (CLK),
		.RESET_N  (RESET_N),
		.clear    (clear),
		.push     (beatSel && memBeat.valid),
		.pushData (memBeat.data),
		.pop      (pop),
		.popData  (fifoData),
		.full     (),
		.empty    (fifoEmpty),
		.used     (fifoUsed)
	);

	// Below one burst, refill; room is guaranteed by FIFO depth
	assign burstReq = (cfg.burstLen != '0) && (len_t'(fifoUsed) < cfg.burstLen);

	assign userBeat = '{valid: rdValid, data: fifoData};

	always_ff @(posedge CLK or negedge RESET_N)
	begin
		if (!RESET_N)
			rdValid <= 1'b0;
		else
			rdValid <= pop && !fifoEmpty && !clear;	// Same rule as FIFO pop
	end

	// ========================================
	// Address ring
	// ========================================
	always_ff @(posedge CLK or negedge RESET_N)
	begin
		if (!RESET_N)
			addr <= '0;
		else if (clear)
			addr <= cfg.startAddr;
		else if (burstDone)
			addr <= nextRingAddr(addr, cfg);	// Step or wrap
	end

endmodule

`default_nettype wire

// File: burstArbiter.sv
// Fixed-priority burst arbiter
// Grant register, burst address and length latch, done routing
`timescale 1ns/1ps
`default_nettype none

module burstArbiter
(
	input  logic                                                   CLK,
	input  logic                                                   RESET_N,
	input  logic                [portPkg::NumWritePorts-1:0]       wrReq,
	input  logic                [portPkg::NumReadPorts-1:0]        rdReq,
	input  memBusPkg::addr_t    [portPkg::NumWritePorts-1:0]       wrAddr,
	input  memBusPkg::addr_t    [portPkg::NumReadPorts-1:0]        rdAddr,
	input  portPkg::streamCfg_t [portPkg::NumWritePorts-1:0]       wrCfg,
	input  portPkg::streamCfg_t [portPkg::NumReadPorts-1:0]        rdCfg,
	input  logic                                                   anyClear,
	input  logic                                                   done,
	output portPkg::grant_t                                        grant,
	output memBusPkg::addr_t                                       burstAddr,
	output memBusPkg::len_t                                        burstLen,
	output logic                [portPkg::NumWritePorts-1:0]       wrDone,
	output logic                [portPkg::NumReadPorts-1:0]        rdDone
);

	import memBusPkg::*;
	import portPkg::*;

	grant_t pick;	// Winner this cycle
	addr_t  pickAddr;
	len_t   pickLen;
	logic   loadGrant;

	// ========================================
	// Priority select
	// ========================================
	// Loops run from lowest priority up, later hits override
	always_comb
	begin
		pick     = '0;
		pickAddr = '0;
		pickLen  = '0;
		for (int i = NumReadPorts - 1; i >= 0; i--)
		begin
			if (rdReq[i])
			begin
				pick.valid = 1'b1;
				pick.read  = 1'b1;
				pick.port  = PortIdxWidth'(i);
				pickAddr   = rdAddr[i];
				pickLen    = rdCfg[i].burstLen;
			end
		end
		for (int i = NumWritePorts - 1; i >= 0; i--)
		begin
			if (wrReq[i])
			begin
				pick.valid = 1'b1;
				pick.read  = 1'b0;	// Writes beat all reads
				pick.port  = PortIdxWidth'(i);
				pickAddr   = wrAddr[i];
				pickLen    = wrCfg[i].burstLen;
			end
		end
	end

	// New grant only when idle and no stream is clearing
	assign loadGrant = !grant.valid && !anyClear && pick.valid;

	always_ff @(posedge CLK or negedge RESET_N)
	begin
		if (!RESET_N)
			grant <= '0;
		else if (grant.valid)
		begin
			if (done)
				grant.valid <= 1'b0;	// Release at end of burst
		end
		else if (loadGrant)
			grant <= pick;
	end

	always_ff @(posedge CLK)
	begin
		if (loadGrant)
		begin
			burstAddr <= pickAddr;	// Held through the burst
			burstLen  <= pickLen;
		end
	end

	// Done pulse back to the owner, one-hot
	always_comb
	begin
		for (int i = 0; i < NumWritePorts; i++)
			wrDone[i] = done && grant.valid && !grant.read && (grant.port == PortIdxWidth'(i));
		for (int i = 0; i < NumReadPorts; i++)
			rdDone[i] = done && grant.valid && grant.read && (grant.port == PortIdxWidth'(i));
	end

endmodule

`default_nettype wire

// File: burstSequencer.sv
// Burst sequencer FSM
// Command issue, write beat streaming, read beat counting, done pulse
`timescale 1ns/1ps
`default_nettype none

module burstSequencer
(
	input  logic                                        CLK,
	input  logic                                        RESET_N,
	input  portPkg::grant_t                             grant,
	input  memBusPkg::addr_t                            burstAddr,
	input  memBusPkg::len_t                             burstLen,
	output memBusPkg::memCmd_t                          memCmd,
	input  memBusPkg::word_t                            wrData,	// Granted FIFO head
	output memBusPkg::beat_t                            memWrBeat,
	output logic               [portPkg::NumWritePorts-1:0] wrSel,
	output logic               [portPkg::NumReadPorts-1:0]  rdSel,
	input  memBusPkg::beat_t                            memRdBeat,
	output logic                                        done
);

	import memBusPkg::*;
	import portPkg::*;

	typedef enum logic [2:0] {
		SeqIdle,
		SeqCmd,	// Command on the bus
		SeqWrite,
		SeqRead,
		SeqDone
	} seqState_t;

	seqState_t state;
	len_t      beatCnt;	// Beats moved so far
	len_t      lastBeat;
	logic      popNow;

	assign lastBeat = burstLen - len_t'(1);

	// FIFO output is registered, so pops run one cycle ahead of beats
	assign popNow = (state == SeqCmd && !grant.read) ||
	                (state == SeqWrite && beatCnt != lastBeat);

	assign memWrBeat = '{valid: (state == SeqWrite), data: wrData};
	assign done      = (state == SeqDone);

	// Channel selects
	always_comb
	begin
		for (int i = 0; i < NumWritePorts; i++)
			wrSel[i] = popNow && (grant.port == PortIdxWidth'(i));
		for (int i = 0; i < NumReadPorts; i++)
			rdSel[i] = (state == SeqRead) && (grant.port == PortIdxWidth'(i));	// Push gated by beat valid
	end

	// ========================================
	// Burst FSM
	// ========================================
	always_ff @(posedge CLK or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			state   <= SeqIdle;
			beatCnt <= '0;
			memCmd  <= '0;
		end
		else
		begin
			memCmd.valid <= 1'b0;	// Single-cycle command
			case (state)
				SeqIdle:
					if (grant.valid)
					begin
						memCmd.valid <= 1'b1;
						memCmd.write <= !grant.read;
						memCmd.addr  <= burstAddr;
						memCmd.len   <= burstLen;
						state        <= SeqCmd;
					end
				SeqCmd:
				begin
					beatCnt <= '0;
					state   <= grant.read ? SeqRead : SeqWrite;
				end
				SeqWrite:
				begin
					beatCnt <= beatCnt + 1'b1;	// One beat every cycle
					if (beatCnt == lastBeat)
						state <= SeqDone;
				end
				SeqRead:
					if (memRdBeat.valid)	// Beats arrive with gaps
					begin
						beatCnt <= beatCnt + 1'b1;
						if (beatCnt == lastBeat)
							state <= SeqDone;
					end
				SeqDone:
					state <= SeqIdle;	// Grant drops on this edge too
				default:
					state <= SeqIdle;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: multiPortSdramCtrl.sv
// Multi-port burst memory controller top
// Write and read channel arrays, arbiter and sequencer
`timescale 1ns/1ps
`default_nettype none

module multiPortSdramCtrl
(
	input  logic                                                CLK,
	input  logic                                                RESET_N,
	// Write streams
	input  memBusPkg::beat_t    [portPkg::NumWritePorts-1:0]    wrBeat,
	input  portPkg::streamCfg_t [portPkg::NumWritePorts-1:0]    wrCfg,
	input  logic                [portPkg::NumWritePorts-1:0]    wrClear,
	output logic                [portPkg::NumWritePorts-1:0]    wrReady,
	// Read streams
	input  portPkg::streamCfg_t [portPkg::NumReadPorts-1:0]     rdCfg,
	input  logic                [portPkg::NumReadPorts-1:0]     rdClear,
	input  logic                [portPkg::NumReadPorts-1:0]     rdPop,
	output memBusPkg::beat_t    [portPkg::NumReadPorts-1:0]     rdBeat,
	// External burst bus
	output memBusPkg::memCmd_t                                  memCmd,
	output memBusPkg::beat_t                                    memWrBeat,
	input  memBusPkg::beat_t                                    memRdBeat
);

	import memBusPkg::*;
	import portPkg::*;

	logic  [NumWritePorts-1:0] wrReq;
	logic  [NumReadPorts-1:0]  rdReq;
	addr_t [NumWritePorts-1:0] wrAddr;	// Ring positions
	addr_t [NumReadPorts-1:0]  rdAddr;
	logic  [NumWritePorts-1:0] wrDone;
	logic  [NumReadPorts-1:0]  rdDone;
	logic  [NumWritePorts-1:0] wrSel;
	logic  [NumReadPorts-1:0]  rdSel;
	word_t [NumWritePorts-1:0] wrMemData;	// FIFO heads toward memory
	word_t                     seqWrData;
	grant_t                    grant;
	addr_t                     burstAddr;
	len_t                      burstLen;
	logic                      seqDone;
	logic                      anyClear;

	assign anyClear  = (|wrClear) | (|rdClear);	// Any clear stalls new grants
	assign seqWrData = wrMemData[grant.port];

	// ========================================
	// Stream channels
	// ========================================
	for (genvar i = 0; i < NumWritePorts; i++)
	begin : genWrite
		writeChannel i_wrChannel
		(
			.CLK       (CLK),
			.RESET_N   (RESET_N),
			.cfg       (wrCfg[i]),
			.clear     (wrClear[i]),
			.userBeat  (wrBeat[i]),
			.ready     (wrReady[i]),
			.beatSel   (wrSel[i]),
			.memData   (wrMemData[i]),
			.burstDone (wrDone[i]),
			.burstReq  (wrReq[i]),
			.addr      (wrAddr[i])
		);
	end

	for (genvar i = 0; i < NumReadPorts; i++)
	begin : genRead
		readChannel i_rdChannel
		(
			.CLK       (CLK),
			.RESET_N   (RESET_N),
			.cfg       (rdCfg[i]),
			.clear     (rdClear[i]),
			.beatSel   (rdSel[i]),
			.memBeat   (memRdBeat),	// Shared return path
			.pop       (rdPop[i]),
			.userBeat  (rdBeat[i]),
			.burstDone (rdDone[i]),
			.burstReq  (rdReq[i]),
			.addr      (rdAddr[i])
		);
	end

	// ========================================
	// Arbitration and burst control
	// ========================================
	burstArbiter i_arbiter
	(
		.CLK       (CLK),
		.RESET_N   (RESET_N),
		.wrReq     (wrReq),
		.rdReq     (rdReq),
		.wrAddr    (wrAddr),
		.rdAddr    (rdAddr),
		.wrCfg     (wrCfg),
		.rdCfg     (rdCfg),
		.anyClear  (anyClear),
		.done      (seqDone),
		.grant     (grant),
		.burstAddr (burstAddr),
		.burstLen  (burstLen),
		.wrDone    (wrDone),
		.rdDone    (rdDone)
	);

	burstSequencer i_sequencer
	(
		.CLK       (CLK),
		.RESET_N   (RESET_N),
		.grant     (grant),
		.burstAddr (burstAddr),
		.burstLen  (burstLen),
		.memCmd    (memCmd),
		.wrData    (seqWrData),
		.memWrBeat (memWrBeat),
		.wrSel     (wrSel),
		.rdSel     (rdSel),
		.memRdBeat (memRdBeat),
		.done      (seqDone)
	);

endmodule

`default_nettype wire

// File: sdramCtrl_checker.sv
// Concurrent assertions on the burst sequencer, bound into the DUT
`timescale 1ns/1ps
`default_nettype none

module sdramCtrl_checker
(
	input  logic                CLK,
	input  logic                RESET_N,
	input  memBusPkg::memCmd_t  memCmd,
	input  memBusPkg::beat_t    memWrBeat,
	input  logic                done
);

	import memBusPkg::*;

	int   failCount = 0;	// Read by the testbench top
	logic inBurst;
	logic isWrite;
	len_t cmdLen;
	len_t wrBeats;	// Write beats since the command

	always_ff @(posedge CLK or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			inBurst <= 1'b0;
			isWrite <= 1'b0;
			cmdLen  <= '0;
			wrBeats <= '0;
		end
		else if (memCmd.valid)
		begin
			inBurst <= 1'b1;
			isWrite <= memCmd.write;
			cmdLen  <= memCmd.len;
			wrBeats <= '0;
		end
		else
		begin
			if (memWrBeat.valid)
				wrBeats <= wrBeats + 1'b1;
			if (done)
				inBurst <= 1'b0;	// Burst closed
		end
	end

	cmdOutsideBurst: assert property (@(posedge CLK) disable iff (!RESET_N)
		memCmd.valid |-> !inBurst)
	else
	begin
		$error("command issued during a running burst");
		failCount++;
	end

	wrBeatCount: assert property (@(posedge CLK) disable iff (!RESET_N)
		(done && isWrite) |-> (wrBeats == cmdLen))
	else
	begin
		$error("write beat count differs from burst length");
		failCount++;
	end

	donePulse: assert property (@(posedge CLK) disable iff (!RESET_N)
		done |=> !done)
	else
	begin
		$error("done held longer than one cycle");
		failCount++;
	end

endmodule

bind burstSequencer sdramCtrl_checker i_checker
(
	.CLK       (CLK),
	.RESET_N   (RESET_N),
	.memCmd    (memCmd),
	.memWrBeat (memWrBeat),
	.done      (done)
);

`default_nettype wire

// File: tbScoreboard.sv
// Testbench scoreboard for the multi-port controller
// Predicts ring addresses, write data and read data, counts errors
`timescale 1ns/1ps
`default_nettype none

module tbScoreboard
(
	input  logic                                             CLK,
	input  logic                                             RESET_N,
	input  memBusPkg::beat_t    [portPkg::NumWritePorts-1:0] wrBeat,
	input  logic                [portPkg::NumWritePorts-1:0] wrReady,
	input  portPkg::streamCfg_t [portPkg::NumWritePorts-1:0] wrCfg,
	input  logic                [portPkg::NumWritePorts-1:0] wrClear,
	input  portPkg::streamCfg_t [portPkg::NumReadPorts-1:0]  rdCfg,
	input  logic                [portPkg::NumReadPorts-1:0]  rdClear,
	input  memBusPkg::beat_t    [portPkg::NumReadPorts-1:0]  rdBeat,
	input  memBusPkg::memCmd_t                               memCmd,
	input  memBusPkg::beat_t                                 memWrBeat,
	input  memBusPkg::beat_t                                 memRdBeat,
	input  logic                                             orderArm	// Expect wr0, wr1, rd0 next
);

	import memBusPkg::*;
	import portPkg::*;

	int         errCount = 0;
	int         wrLeft [NumWritePorts];	// Accepted words not yet on the bus
	int         rdGot [NumReadPorts];	// Words handed to the read user
	logic       busy;	// Burst in flight
	word_t      wrQ [NumWritePorts][$];
	word_t      rdQ [NumReadPorts][$];
	addr_t      ringAddr [4];	// Next burst address per stream
	int         expOrder [$];
	int         curStream;
	int         beatsLeft;
	int         s;
	streamCfg_t cfgNow;

	// Read regions are never written, so they keep the preset pattern
	function automatic word_t fillWord(addr_t a);
		return word_t'(a[15:0] ^ {a[21:16], a[21:12]} ^ 16'h3c5a);
	endfunction

	// Step by length, back to start when the next burst would pass wrap
	function automatic addr_t ringStep(addr_t a, streamCfg_t c);
		if (a + 2 * c.burstLen > c.wrapAddr)
			return c.startAddr;
		return a + c.burstLen;
	endfunction

	task automatic reportFail(string msg);
		errCount++;
		$display("[FAIL] %0t ns: %s", $time, msg);
	endtask

	always @(posedge CLK or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			if (memCmd.valid || memWrBeat.valid || rdBeat[0].valid || rdBeat[1].valid)
				reportFail("output valid during reset");
			for (int i = 0; i < 4; i++)
				ringAddr[i] = '0;	// Rings reset to zero
			for (int i = 0; i < NumWritePorts; i++)
			begin
				wrQ[i].delete();
				wrLeft[i] = 0;
			end
			for (int i = 0; i < NumReadPorts; i++)
			begin
				rdQ[i].delete();
				rdGot[i] = 0;
			end
			expOrder.delete();
			beatsLeft = 0;
			curStream = -1;
			busy      = 1'b0;
		end
		else
		begin
			// ========================================
			// User side, clears and accepted words
			// ========================================
			for (int i = 0; i < NumWritePorts; i++)
			begin
				// Level is exact unless this stream's pops run ahead of its beats
				if (wrQ[i].size() < FifoDepth && wrReady[i] !== 1'b1)
					reportFail($sformatf("write %0d ready low with %0d words buffered",
						i, wrQ[i].size()));
				else if (wrQ[i].size() >= FifoDepth && !(busy && curStream == i) &&
					wrReady[i] !== 1'b0)
					reportFail($sformatf("write %0d ready high with the FIFO full", i));
				if (wrClear[i])
				begin
					wrQ[i].delete();
					ringAddr[i] = wrCfg[i].startAddr;	// Rewind
				end
				else if (wrBeat[i].valid && wrReady[i])
					wrQ[i].push_back(wrBeat[i].data);
			end
			for (int i = 0; i < NumReadPorts; i++)
			begin
				if (rdBeat[i].valid)
				begin
					if (rdQ[i].size() == 0)
						reportFail($sformatf("read %0d returned a word with none expected", i));
					else if (rdBeat[i].data !== rdQ[i][0])
						reportFail($sformatf("read %0d data %h, expected %h",
							i, rdBeat[i].data, rdQ[i][0]));
					if (rdQ[i].size() > 0)
						void'(rdQ[i].pop_front());
					rdGot[i]++;
				end
				if (rdClear[i])
				begin
					rdQ[i].delete();
					rdGot[i]    = 0;
					ringAddr[2 + i] = rdCfg[i].startAddr;
				end
			end
			if (orderArm)
				expOrder = '{0, 1, 2};

			// ========================================
			// Burst bus
			// ========================================
			if (memCmd.valid)
			begin
				s = int'(memCmd.addr[14:12]) - 1;	// Region gives the stream
				if (beatsLeft != 0)
					reportFail("a command started while a burst was still running");
				if (s < 0 || s > 3 || memCmd.write != (s < 2))
					reportFail($sformatf("command at %h outside any stream region", memCmd.addr));
				else
				begin
					cfgNow = (s < 2) ? wrCfg[s] : rdCfg[s - 2];
					if (expOrder.size() > 0)
					begin
						if (s != expOrder[0])
							reportFail($sformatf("stream %0d, expected stream %0d by priority",
								s, expOrder[0]));
						void'(expOrder.pop_front());
					end
					if (memCmd.addr !== ringAddr[s] || memCmd.len !== cfgNow.burstLen)
						reportFail($sformatf("stream %0d cmd %h/%0d, expected %h/%0d", s,
							memCmd.addr, memCmd.len, ringAddr[s], cfgNow.burstLen));
					if (s >= 2)
						for (int k = 0; k < memCmd.len; k++)
							rdQ[s - 2].push_back(fillWord(memCmd.addr + k));
					ringAddr[s] = ringStep(ringAddr[s], cfgNow);
					curStream   = s;
					beatsLeft   = memCmd.len;
				end
			end
			if (memWrBeat.valid)
			begin
				if (curStream < 0 || curStream > 1 || beatsLeft == 0)
					reportFail("write beat outside a write burst");
				else
				begin
					if (wrQ[curStream].size() == 0)
						reportFail($sformatf("write %0d beat with no user word", curStream));
					else if (memWrBeat.data !== wrQ[curStream][0])
						reportFail($sformatf("write %0d data %h, expected %h",
							curStream, memWrBeat.data, wrQ[curStream][0]));
					if (wrQ[curStream].size() > 0)
						void'(wrQ[curStream].pop_front());
					beatsLeft--;
				end
			end
			if (memRdBeat.valid)
			begin
				if (curStream < 2 || beatsLeft == 0)
					reportFail("read beat outside a read burst");
				else
					beatsLeft--;
			end
			for (int i = 0; i < NumWritePorts; i++)
				wrLeft[i] = wrQ[i].size();
			busy = (beatsLeft != 0);
		end
	end

endmodule

`default_nettype wire

// File: tbMultiPortSdramCtrl.sv
// Testbench top for the multi-port controller
// Clock, reset, stimulus table, burst memory model and watchdog
`timescale 1ns/1ps
`default_nettype none

module tbMultiPortSdramCtrl;

	import memBusPkg::*;
	import portPkg::*;

	localparam int ClkPeriod   = 40;
	localparam int ResetCycles = 10;
	localparam int ReadLatency = 3;	// Cycles from command to first read beat
	localparam int NumSteps    = 7;
	localparam int OrderWords  = 24;	// Words moved by the priority test
	localparam int FullWords   = FifoDepth;	// Words that fill one write FIFO

	// One table row, stream 0/1 write, 2/3 read
	typedef struct packed {
		logic [1:0]  stream;
		addr_t       startAddr;
		addr_t       wrapAddr;
		len_t        burstLen;
		logic [15:0] words;
		logic        clear;
	} step_t;

	logic                                CLK;
	logic                                RESET_N;
	beat_t      [NumWritePorts-1:0]      wrBeat;
	streamCfg_t [NumWritePorts-1:0]      wrCfg;
	logic       [NumWritePorts-1:0]      wrClear;
	logic       [NumWritePorts-1:0]      wrReady;
	streamCfg_t [NumReadPorts-1:0]       rdCfg;
	logic       [NumReadPorts-1:0]       rdClear;
	logic       [NumReadPorts-1:0]       rdPop;
	beat_t      [NumReadPorts-1:0]       rdBeat;
	memCmd_t                             memCmd;
	beat_t                               memWrBeat;
	beat_t                               memRdBeat;
	logic                                orderArm;

	integer  seed = 32'h2dea_d937;
	step_t   steps [NumSteps];
	word_t   mem [addr_t];	// Sparse memory, unwritten words hold the pattern
	addr_t   rdAddrQ [$];
	addr_t   wrPtr;
	longint  cycle = 0;
	longint  rdReadyAt = 0;
	int      totalErrors;

	multiPortSdramCtrl i_dut
	(
		.CLK       (CLK),
		.RESET_N   (RESET_N),
		.wrBeat    (wrBeat),
		.wrCfg     (wrCfg),
		.wrClear   (wrClear),
		.wrReady   (wrReady),
		.rdCfg     (rdCfg),
		.rdClear   (rdClear),
		.rdPop     (rdPop),
		.rdBeat    (rdBeat),
		.memCmd    (memCmd),
		.memWrBeat (memWrBeat),
		.memRdBeat (memRdBeat)
	);

	tbScoreboard i_scoreboard
	(
		.CLK       (CLK),
		.RESET_N   (RESET_N),
		.wrBeat    (wrBeat),
		.wrReady   (wrReady),
		.wrCfg     (wrCfg),
		.wrClear   (wrClear),
		.rdCfg     (rdCfg),
		.rdClear   (rdClear),
		.rdBeat    (rdBeat),
		.memCmd    (memCmd),
		.memWrBeat (memWrBeat),
		.memRdBeat (memRdBeat),
		.orderArm  (orderArm)
	);

	initial
	begin
		CLK = 1'b0;
		forever #(ClkPeriod / 2) CLK = ~CLK;
	end

	// ========================================
	// Memory model
	// ========================================
	function automatic word_t fillWord(addr_t a);
		return word_t'(a[15:0] ^ {a[21:16], a[21:12]} ^ 16'h3c5a);
	endfunction

	always @(posedge CLK)
	begin
		cycle++;
		if (memCmd.valid && memCmd.write)
			wrPtr = memCmd.addr;
		else if (memCmd.valid)
		begin
			for (int k = 0; k < memCmd.len; k++)
				rdAddrQ.push_back(memCmd.addr + k);
			rdReadyAt = cycle + ReadLatency;
		end
		if (memWrBeat.valid)
		begin
			mem[wrPtr] = memWrBeat.data;
			wrPtr++;
		end
	end

	// Read return with random gaps
	initial
	begin
		memRdBeat = '0;
		forever
		begin
			@(posedge CLK);
			#1;
			memRdBeat = '0;
			if (rdAddrQ.size() > 0 && cycle >= rdReadyAt && ($random(seed) & 3) != 0)
			begin
				memRdBeat.valid = 1'b1;
				memRdBeat.data  = mem.exists(rdAddrQ[0]) ? mem[rdAddrQ[0]] : fillWord(rdAddrQ[0]);
				void'(rdAddrQ.pop_front());
			end
		end
	end

	// ========================================
	// Stimulus tasks
	// ========================================
	task automatic setStream(int s, streamCfg_t cfg, bit doClear);
		@(posedge CLK);
		#1;
		if (s < 2)
		begin
			wrCfg[s]   = cfg;
			wrClear[s] = doClear;
		end
		else
		begin
			rdCfg[s - 2]   = cfg;
			rdClear[s - 2] = doClear;
		end
		@(posedge CLK);
		#1;
		if (s < 2)
			wrClear[s] = 1'b0;
		else
			rdClear[s - 2] = 1'b0;
	endtask

	task automatic pushWords(int s, int n);
		int k;
		bit taken;
		k = 0;
		wrBeat[s] = '{valid: 1'b1, data: word_t'($random(seed))};
		while (k < n)
		begin
			taken = wrReady[s];	// Stable until the next edge
			@(posedge CLK);
			#1;
			if (taken)
			begin
				k++;
				wrBeat[s].data = word_t'($random(seed));
			end
		end
		wrBeat[s] = '0;
	endtask

	task automatic popWords(int r, int n);
		rdPop[r] = 1'b1;
		while (i_scoreboard.rdGot[r] < n)
		begin
			@(posedge CLK);
			#1;
		end
		rdPop[r] = 1'b0;
	endtask

	// Several cycles with no burst in flight
	task automatic waitQuiet();
		int quiet;
		quiet = 0;
		while (quiet < 6)
		begin
			@(posedge CLK);
			#1;
			quiet = i_scoreboard.busy ? 0 : quiet + 1;
		end
	endtask

	task automatic retireRead(int r);
		streamCfg_t cfg;
		waitQuiet();	// Refills end once the FIFO holds a burst
		cfg          = rdCfg[r];
		cfg.burstLen = '0;	// Stop refills
		rdCfg[r]     = cfg;
		setStream(r + 2, cfg, 1'b1);	// Flush prefetched words
	endtask

	task automatic runStep(step_t st);
		streamCfg_t cfg;
		cfg = '{startAddr: st.startAddr, wrapAddr: st.wrapAddr, burstLen: st.burstLen};
		setStream(st.stream, cfg, st.clear);
		if (st.stream < 2)
		begin
			pushWords(st.stream, st.words);
			while (i_scoreboard.wrLeft[st.stream] != 0)
				@(posedge CLK);
			#1;
		end
		else
		begin
			popWords(st.stream - 2, st.words);
			retireRead(st.stream - 2);
		end
		waitQuiet();
	endtask

	// Both writes full and rd0 empty when a held clear drops
	task automatic checkPriority();
		@(posedge CLK);
		#1;
		rdClear  = 2'b11;	// rd1 clear stalls grants
		wrClear  = 2'b11;
		wrCfg[0] = '{startAddr: 22'h001000, wrapAddr: 22'h001100, burstLen: 8'd8};
		wrCfg[1] = '{startAddr: 22'h002000, wrapAddr: 22'h002100, burstLen: 8'd8};
		rdCfg[0] = '{startAddr: 22'h003000, wrapAddr: 22'h003100, burstLen: 8'd4};
		@(posedge CLK);
		#1;
		wrClear = 2'b00;
		rdClear = 2'b10;
		for (int k = 0; k < 8; k++)
		begin
			wrBeat[0] = '{valid: 1'b1, data: word_t'($random(seed))};
			wrBeat[1] = '{valid: 1'b1, data: word_t'($random(seed))};
			@(posedge CLK);
			#1;
		end
		wrBeat   = '0;
		orderArm = 1'b1;
		rdClear  = 2'b00;
		@(posedge CLK);
		#1;
		orderArm = 1'b0;
		popWords(0, 8);
		while (i_scoreboard.wrLeft[0] != 0 || i_scoreboard.wrLeft[1] != 0)
			@(posedge CLK);
		#1;
		retireRead(0);
		waitQuiet();
	endtask

	// Disabled write stream fills its FIFO until ready drops
	task automatic checkFull();
		streamCfg_t cfg;
		cfg = '{startAddr: 22'h002000, wrapAddr: 22'h002100, burstLen: 8'd0};
		setStream(1, cfg, 1'b1);
		pushWords(1, FullWords);
		setStream(1, cfg, 1'b1);	// Empty the full FIFO
		waitQuiet();
	endtask

	// ========================================
	// Main sequence and watchdog
	// ========================================
	initial
	begin
		steps[0] = '{2'd0, 22'h001000, 22'h001028, 8'd8, 16'd48, 1'b1};	// Wraps after 5
		steps[1] = '{2'd1, 22'h002000, 22'h002030, 8'd16, 16'd64, 1'b1};
		steps[2] = '{2'd2, 22'h003000, 22'h003018, 8'd8, 16'd40, 1'b1};
		steps[3] = '{2'd3, 22'h004000, 22'h00400c, 8'd4, 16'd20, 1'b1};
		steps[4] = '{2'd0, 22'h001000, 22'h001028, 8'd8, 16'd16, 1'b0};	// Ring carries on
		steps[5] = '{2'd0, 22'h001000, 22'h001028, 8'd8, 16'd16, 1'b1};	// Rewind
		steps[6] = '{2'd2, 22'h003000, 22'h003010, 8'd4, 16'd12, 1'b1};
		RESET_N  = 1'b0;
		wrBeat   = '0;
		wrCfg    = '0;
		wrClear  = '0;
		rdCfg    = '0;
		rdClear  = '0;
		rdPop    = '0;
		orderArm = 1'b0;
		repeat (ResetCycles) @(posedge CLK);
		#1;
		RESET_N = 1'b1;
		repeat (8) @(posedge CLK);	// Nothing configured, bus must stay idle
		#1;
		for (int i = 0; i < NumSteps; i++)
			runStep(steps[i]);
		checkPriority();
		checkFull();
		totalErrors = i_scoreboard.errCount + i_dut.i_sequencer.i_checker.failCount;
		$display("Errors: scoreboard %0d, assertions %0d", i_scoreboard.errCount,
			i_dut.i_sequencer.i_checker.failCount);
		if (totalErrors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

	initial
	begin
		longint limit;
		int words;
		#1;
		words = OrderWords + FullWords;
		for (int i = 0; i < NumSteps; i++)
			words += steps[i].words;
		limit = longint'(words) * 12 + 3000;	// Cycles, with slack for step overhead
		repeat (limit) @(posedge CLK);
		$display("Timeout: run did not finish within %0d cycles", limit);
		$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: flist.f
memBusPkg.sv
portPkg.sv
portFifo.sv
writeChannel.sv
readChannel.sv
burstArbiter.sv
burstSequencer.sv
multiPortSdramCtrl.sv
sdramCtrl_checker.sv
tbScoreboard.sv
tbMultiPortSdramCtrl.sv

// File: Bender.yml
package:
  name: multi_port_sdram_ctrl

sources:
  - memBusPkg.sv
  - portPkg.sv
  - portFifo.sv
  - writeChannel.sv
  - readChannel.sv
  - burstArbiter.sv
  - burstSequencer.sv
  - multiPortSdramCtrl.sv
  - target: test
    files:
      - sdramCtrl_checker.sv
      - tbScoreboard.sv
      - tbMultiPortSdramCtrl.sv
